//--- src/ucpd_rx_pkg.sv
// shared widths, K-codes, item types and 4b5b decode for the PD receive chain, used by scoped name
package ucpd_rx_pkg;

  // --------------------
  // line symbols
  localparam int SYM_W = 5; // one 4b5b code group

  typedef logic [SYM_W-1:0] sym_t;

  localparam sym_t K_SYNC1 = 5'b11000; // sync-1
  localparam sym_t K_SYNC2 = 5'b10001; // sync-2
  localparam sym_t K_SYNC3 = 5'b00110; // sync-3
  localparam sym_t K_RST1  = 5'b00111; // rst-1
  localparam sym_t K_RST2  = 5'b11001; // rst-2
  localparam sym_t K_EOP   = 5'b01101; // end of packet

  typedef logic [3:0] nibble_t;   // decoded data half byte
  typedef logic [9:0] byte_cnt_t; // payload bytes per frame

  // --------------------
  // ordered set result
  typedef enum logic [2:0] {
    OS_SOP       = 3'd0,
    OS_SOP1      = 3'd1, // sop'
    OS_SOP2      = 3'd2, // sop''
    OS_HARD_RST  = 3'd3,
    OS_CABLE_RST = 3'd4,
    OS_INVALID   = 3'd5  // no sequence reached 3 of 4
  } ordset_e;

  typedef struct packed {
    ordset_e    kind;
    logic [2:0] corrupt_idx;   // 0 clean, 1..4 the bad K-code
    logic       three_of_four; // matched with one K-code off
  } ordset_t;

  // --------------------
  // receive items
  typedef enum logic [1:0] {
    ITEM_ORDSET = 2'd0,
    ITEM_BYTE   = 2'd1,
    ITEM_EOP    = 2'd2,
    ITEM_ERROR  = 2'd3
  } item_kind_e;

  typedef struct packed {
    item_kind_e kind;
    ordset_t    ordset; // only meaningful for ITEM_ORDSET
    logic [7:0] data;   // byte, eop count or bad symbol
  } rx_item_t;

  // 4b5b data table, returns 0 for K-codes and unused groups
  function automatic logic decode_4b5b(input sym_t sym, output nibble_t nib);
    logic ok;
    ok  = 1'b1;
    nib = 4'h0;
    case (sym)
      5'b11110: nib = 4'h0;
      5'b01001: nib = 4'h1;
      5'b10100: nib = 4'h2;
      5'b10101: nib = 4'h3;
      5'b01010: nib = 4'h4;
      5'b01011: nib = 4'h5;
      5'b01110: nib = 4'h6;
      5'b01111: nib = 4'h7;
      5'b10010: nib = 4'h8;
      5'b10011: nib = 4'h9;
      5'b10110: nib = 4'hA;
      5'b10111: nib = 4'hB;
      5'b11010: nib = 4'hC;
      5'b11011: nib = 4'hD;
      5'b11100: nib = 4'hE;
      5'b11101: nib = 4'hF;
      default:  ok  = 1'b0; // not a data group
    endcase
    return ok;
  endfunction

endpackage

//--- src/ucpd_symbol_shifter.sv
// collects decoded line bits LSB first into 5-bit symbols, realigned by frame_start
`timescale 1ns/1ns

module ucpd_symbol_shifter (
  input  logic              ucpd_clk,
  input  logic              ic_rst_n,
  input  logic              frame_start, // restart symbol alignment
  input  logic              line_valid,
  input  logic              line_bit,
  output logic              sym_valid,   // one-cycle pulse per symbol
  output ucpd_rx_pkg::sym_t sym
);

  logic [3:0] shreg;   // first four bits of the symbol
  logic [2:0] bit_cnt; // bits taken so far, 0..4

  // --------------------
  // bit counter and pulse
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      bit_cnt   <= 3'd0;
      sym_valid <= 1'b0;
    end
    else
    begin
      sym_valid <= 1'b0;                     // default, pulse only
      if (frame_start)
        bit_cnt <= 3'd0;                     // new frame, new alignment
      else if (line_valid)
      begin
        if (bit_cnt == 3'd4)
        begin
          bit_cnt   <= 3'd0;
          sym_valid <= 1'b1;                 // fifth bit completes it
        end
        else
          bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // shift path, payload only
  always_ff @(posedge ucpd_clk)
  begin
    if (line_valid)
    begin
      shreg <= {line_bit, shreg[3:1]};       // oldest bit drifts toward lsb
      if (bit_cnt == 3'd4)
        sym <= {line_bit, shreg};            // first bit lands in bit 0
    end
  end

  // the line must be quiet on the cycle that marks the preamble end
  a_no_bit_on_start: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    !(line_valid && frame_start));

endmodule

//--- src/ucpd_ordset_detector.sv
// classifies the first four K-codes of a frame as an ordered set using the 3-of-4 rule
`timescale 1ns/1ns

module ucpd_ordset_detector (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 frame_start,
  input  logic                 sym_valid,
  input  ucpd_rx_pkg::sym_t    sym,
  output logic                 os_valid,  // once per frame
  output ucpd_rx_pkg::ordset_t os
);

  localparam int N_SEQ = 5; // sop, sop', sop'', hard rst, cable rst

  // reference sequences, element 0 is received first
  localparam ucpd_rx_pkg::sym_t SEQ_TAB [N_SEQ][4] = '{
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC1,
      ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC2},  // sop
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC1,
      ucpd_rx_pkg::K_SYNC3, ucpd_rx_pkg::K_SYNC3},  // sop'
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC3,
      ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC3},  // sop''
    '{ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_RST1,
      ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_RST2},   // hard reset
    '{ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_SYNC1,
      ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_SYNC3}   // cable reset
  };

  localparam ucpd_rx_pkg::ordset_e SEQ_KIND [N_SEQ] = '{
    ucpd_rx_pkg::OS_SOP, ucpd_rx_pkg::OS_SOP1, ucpd_rx_pkg::OS_SOP2,
    ucpd_rx_pkg::OS_HARD_RST, ucpd_rx_pkg::OS_CABLE_RST
  };

  ucpd_rx_pkg::sym_t    k_q [3]; // first three K-codes
  ucpd_rx_pkg::sym_t    win [4]; // candidate set incl. the live fourth
  ucpd_rx_pkg::ordset_t os_nxt;
  logic [2:0]           sym_idx; // 0..3 collecting, 4 done for this frame
  logic                 take;

  assign take = sym_valid && !frame_start && (sym_idx < 3'd4);

  // --------------------
  // 3-of-4 match, first hit in table order wins
  always_comb
  begin
    logic [2:0] hits;
    logic [2:0] miss_pos;
    logic       found;
    win[0]   = k_q[0];
    win[1]   = k_q[1];
    win[2]   = k_q[2];
    win[3]   = sym;                              // fourth symbol is still on the bus
    found    = 1'b0;
    os_nxt.kind          = ucpd_rx_pkg::OS_INVALID;
    os_nxt.corrupt_idx   = 3'd0;
    os_nxt.three_of_four = 1'b0;
    for (int s = 0; s < N_SEQ; s++)
    begin
      hits     = 3'd0;
      miss_pos = 3'd0;
      for (int p = 0; p < 4; p++)
      begin
        if (win[p] == SEQ_TAB[s][p])
          hits = hits + 3'd1;
        else
          miss_pos = 3'(p + 1);                  // 1-based position
      end
      if (!found && (hits >= 3'd3))
      begin
        found                = 1'b1;
        os_nxt.kind          = SEQ_KIND[s];
        os_nxt.corrupt_idx   = miss_pos;         // stays 0 on a clean match
        os_nxt.three_of_four = (hits == 3'd3);
      end
    end
  end

  // --------------------
  // position counter and result pulse
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      sym_idx  <= 3'd4;                          // ignore symbols until a frame starts
      os_valid <= 1'b0;
    end
    else
    begin
      os_valid <= take && (sym_idx == 3'd3);
      if (frame_start)
        sym_idx <= 3'd0;
      else if (take)
        sym_idx <= sym_idx + 3'd1;
    end
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (take && (sym_idx < 3'd3))
      k_q[sym_idx[1:0]] <= sym;
    if (take && (sym_idx == 3'd3))
      os <= os_nxt;
  end

  // a frame carries exactly one ordered set
  a_one_os_per_frame: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    os_valid |=> (!os_valid until frame_start));

endmodule

//--- src/ucpd_data_decoder.sv
// frame phase control: emits ordset, byte, eop and error items and counts payload bytes
`timescale 1ns/1ns

module ucpd_data_decoder (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   frame_start,
  input  logic                   sym_valid,
  input  ucpd_rx_pkg::sym_t      sym,
  input  logic                   os_valid,
  input  ucpd_rx_pkg::ordset_t   os,
  output logic                   wr_valid,   // one item per pulse
  output ucpd_rx_pkg::rx_item_t  wr_item,
  output ucpd_rx_pkg::byte_cnt_t byte_count
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ORDSET,   // waiting for the ordered set result
    PH_DATA      // packet payload until eop
  } phase_e;

  phase_e               phase;
  logic                 half;      // low nibble is waiting
  ucpd_rx_pkg::nibble_t lo_nib;
  ucpd_rx_pkg::nibble_t dec_nib;
  logic                 dec_ok;
  logic                 is_sop;
  logic                 data_sym;
  logic                 emit_os;
  logic                 emit_eop;
  logic                 emit_err;
  logic                 take_nib;
  logic                 emit_byte;

  always_comb
  begin
    dec_ok = ucpd_rx_pkg::decode_4b5b(sym, dec_nib);
  end

  // --------------------
  // event decode
  assign is_sop    = (os.kind == ucpd_rx_pkg::OS_SOP) ||
                     (os.kind == ucpd_rx_pkg::OS_SOP1) ||
                     (os.kind == ucpd_rx_pkg::OS_SOP2);    // any sop carries data
  assign data_sym  = (phase == PH_DATA) && sym_valid && !frame_start;
  assign emit_os   = (phase == PH_ORDSET) && os_valid && !frame_start;
  assign emit_eop  = data_sym && (sym == ucpd_rx_pkg::K_EOP);
  assign emit_err  = data_sym && (sym != ucpd_rx_pkg::K_EOP) && !dec_ok;
  assign take_nib  = data_sym && (sym != ucpd_rx_pkg::K_EOP) && dec_ok;
  assign emit_byte = take_nib && half;                    // second nibble closes a byte

  // --------------------
  // phase, pairing and count
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      phase      <= PH_IDLE;
      half       <= 1'b0;
      wr_valid   <= 1'b0;
      byte_count <= '0;
    end
    else
    begin
      wr_valid <= emit_os || emit_eop || emit_err || emit_byte;
      if (frame_start)
      begin
        phase      <= PH_ORDSET;                          // realign from any phase
        half       <= 1'b0;
        byte_count <= '0;
      end
      else if (emit_os)
        phase <= is_sop ? PH_DATA : PH_IDLE;              // resets have no payload
      else if (emit_eop || emit_err)
      begin
        phase <= PH_IDLE;
        half  <= 1'b0;
      end
      else if (take_nib)
      begin
        half <= !half;
        if (half)
          byte_count <= byte_count + 10'd1;
      end
    end
  end

  // item payload
  always_ff @(posedge ucpd_clk)
  begin
    if (take_nib && !half)
      lo_nib <= dec_nib;                                  // low nibble arrives first
    if (emit_os)
      wr_item <= '{kind: ucpd_rx_pkg::ITEM_ORDSET, ordset: os, data: 8'h00};
    else if (emit_byte)
      wr_item <= '{kind: ucpd_rx_pkg::ITEM_BYTE, ordset: '0, data: {dec_nib, lo_nib}};
    else if (emit_eop)
      wr_item <= '{kind: ucpd_rx_pkg::ITEM_EOP, ordset: '0, data: byte_count[7:0]};
    else if (emit_err)
      wr_item <= '{kind: ucpd_rx_pkg::ITEM_ERROR, ordset: '0, data: {3'b000, sym}};
  end

  // once back in idle only the item that closed the frame may still be pending
  a_no_item_from_idle: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (wr_valid && (phase == PH_IDLE)) |-> (wr_item.kind != ucpd_rx_pkg::ITEM_BYTE));

endmodule

//--- src/ucpd_rx_fifo.sv
// receive item queue with valid/ready output and sticky overflow cleared at frame start
`timescale 1ns/1ns

module ucpd_rx_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  ucpd_clk,
  input  logic                  ic_rst_n,
  input  logic                  frame_start, // clears overflow
  input  logic                  wr_valid,
  input  ucpd_rx_pkg::rx_item_t wr_item,
  output logic                  item_valid,
  output ucpd_rx_pkg::rx_item_t item,
  input  logic                  item_ready,
  output logic                  overflow     // an item was dropped this frame
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  ucpd_rx_pkg::rx_item_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;  // occupancy
  logic                  full;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1; // wrap for any depth
  endfunction

  assign full       = (count == CNT_W'(FIFO_DEPTH));
  assign item_valid = (count != '0);
  assign item       = mem[rd_ptr];           // head of queue
  assign pop        = item_valid && item_ready;
  assign push       = wr_valid && (!full || pop); // a slot frees up on pop

  // --------------------
  // pointers and count
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop)
        rd_ptr <= ptr_next(rd_ptr);
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
      if (frame_start)
        overflow <= 1'b0;
      else if (wr_valid && !push)
        overflow <= 1'b1;                      // sticky until next frame
    end
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (push)
      mem[wr_ptr] <= wr_item;
  end

  // head item must not move while the consumer stalls
  a_hold_when_stalled: assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (item_valid && !item_ready) |=> (item_valid && $stable(item)));

endmodule

//--- src/ucpd_rx_top.sv
// receive chain top: line bits in, ordered sets, bytes, eop and errors out as a stream
`timescale 1ns/1ns

module ucpd_rx_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  logic                   frame_start, // end of preamble
  input  logic                   line_valid,
  input  logic                   line_bit,
  output logic                   item_valid,
  output ucpd_rx_pkg::rx_item_t  item,
  input  logic                   item_ready,
  output logic                   overflow,
  output ucpd_rx_pkg::byte_cnt_t byte_count
);

  logic                  sym_valid;
  ucpd_rx_pkg::sym_t     sym;
  logic                  os_valid;
  ucpd_rx_pkg::ordset_t  os;
  logic                  wr_valid;
  ucpd_rx_pkg::rx_item_t wr_item;

  // --------------------
  // bits to symbols
  ucpd_symbol_shifter u_shift (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .line_valid  (line_valid),
    .line_bit    (line_bit),
    .sym_valid   (sym_valid),
    .sym         (sym)
  );

  ucpd_ordset_detector u_ordset (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .sym_valid   (sym_valid),
    .sym         (sym),
    .os_valid    (os_valid),
    .os          (os)
  );

  ucpd_data_decoder u_dec (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .sym_valid   (sym_valid),
    .sym         (sym),
    .os_valid    (os_valid),
    .os          (os),
    .wr_valid    (wr_valid),
    .wr_item     (wr_item),
    .byte_count  (byte_count)
  );

  // --------------------
  // output queue
  ucpd_rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .wr_valid    (wr_valid),
    .wr_item     (wr_item),
    .item_valid  (item_valid),
    .item        (item),
    .item_ready  (item_ready),
    .overflow    (overflow)
  );

endmodule

//--- dv/ucpd_rx_checker.sv
// testbench checker for the PD receive chain, compares each item transfer and the status outputs
`timescale 1ns/1ns

module ucpd_rx_checker (
  input logic                   ucpd_clk,
  input logic                   ic_rst_n,
  input logic                   item_valid,
  input ucpd_rx_pkg::rx_item_t  item,
  input logic                   item_ready,
  input logic                   overflow,
  input ucpd_rx_pkg::byte_cnt_t byte_count
);

  ucpd_rx_pkg::rx_item_t exp_q [$];   // items still owed by the DUT
  string                 test_name = "none";
  int                    test_errs = 0;
  int                    test_items = 0;
  int                    total_errs = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  int                    checks = 0;

  function automatic int items_pending();
    return exp_q.size();
  endfunction

  task automatic start_test(input string name);
    test_name  = name;
    test_errs  = 0;
    test_items = 0;
    exp_q.delete();                   // nothing carries over
  endtask

  task automatic expect_item(input ucpd_rx_pkg::rx_item_t it);
    exp_q.push_back(it);
  endtask

  // one value check, x or z counts as wrong
  task automatic compare_value(input string sig, input logic [15:0] exp_v,
                               input logic [15:0] got_v);
    checks++;
    if (exp_v !== got_v)
    begin
      $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, got_v);
      test_errs++;
    end
  endtask

  task automatic check_byte_count(input ucpd_rx_pkg::byte_cnt_t exp_cnt);
    compare_value("byte_count", 16'(exp_cnt), 16'(byte_count));
  endtask

  task automatic check_overflow(input logic exp_ovf);
    compare_value("overflow", 16'(exp_ovf), 16'(overflow));
  endtask

  // --------------------
  // per test and total lines
  task automatic finish_test();
    if (exp_q.size() != 0)
    begin
      $display("test %s: %0d expected item(s) never came out of the DUT",
               test_name, exp_q.size());
      test_errs++;
      exp_q.delete();
    end
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0)
      tests_failed++;
    $display("test %-14s %-4s items %0d errors %0d", test_name,
             (test_errs == 0) ? "ok" : "bad", test_items, test_errs);
  endtask

  task automatic report_totals();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errs);
  endtask

  // --------------------
  // item transfer
  always @(posedge ucpd_clk)
  begin
    ucpd_rx_pkg::rx_item_t exp_it;
    if (ic_rst_n && item_valid && item_ready)
    begin
      test_items++;
      if (exp_q.size() == 0)
      begin
        $display("test %s: unexpected item at %0t ns, kind %0d data 0x%02h",
                 test_name, $time, item.kind, item.data);
        test_errs++;
      end
      else
      begin
        exp_it = exp_q.pop_front();                    // oldest expectation first
        compare_value("item.kind", 16'(exp_it.kind), 16'(item.kind));
        compare_value("item.ordset.kind", 16'(exp_it.ordset.kind), 16'(item.ordset.kind));
        compare_value("item.ordset.corrupt_idx", 16'(exp_it.ordset.corrupt_idx),
                      16'(item.ordset.corrupt_idx));
        compare_value("item.ordset.three_of_four", 16'(exp_it.ordset.three_of_four),
                      16'(item.ordset.three_of_four));
        compare_value("item.data", 16'(exp_it.data), 16'(item.data));
      end
    end
  end

endmodule

//--- dv/ucpd_rx_tb.sv
// testbench top for the PD receive chain, replays golden frames bit by bit into the DUT
`timescale 1ns/1ns

module ucpd_rx_tb;

  localparam int    CLK_HALF  = 2;                       // 4 ns period
  localparam int    DRIVE_DLY = 1;                       // input skew after the edge
  localparam int    DRAIN_MAX = 100;                     // cycles allowed for queued items
  localparam string GOLDEN    = "dv/ucpd_rx_golden.txt";

  typedef struct {
    string name;
    int    hold;  // item_ready low through the frame
    int    ovf;   // overflow at the end
    int    cnt;   // byte_count at the end
    int    nsym;
    int    nexp;
  } test_t;

  logic                   ucpd_clk;
  logic                   ic_rst_n;
  logic                   frame_start;
  logic                   line_valid;
  logic                   line_bit;
  logic                   item_valid;
  ucpd_rx_pkg::rx_item_t  item;
  logic                   item_ready;
  logic                   overflow;
  ucpd_rx_pkg::byte_cnt_t byte_count;

  test_t                 tests [$];
  ucpd_rx_pkg::sym_t     syms [$];   // all frames back to back
  ucpd_rx_pkg::rx_item_t exps [$];
  int                    sym_pos;
  int                    exp_pos;
  bit                    ready_rand; // random item_ready each cycle
  bit                    loaded;
  int unsigned           cycle_cnt;
  int unsigned           cycle_limit;

  ucpd_rx_top u_dut (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .frame_start (frame_start),
    .line_valid  (line_valid),
    .line_bit    (line_bit),
    .item_valid  (item_valid),
    .item        (item),
    .item_ready  (item_ready),
    .overflow    (overflow),
    .byte_count  (byte_count)
  );

  ucpd_rx_checker u_chk (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .item_valid  (item_valid),
    .item        (item),
    .item_ready  (item_ready),
    .overflow    (overflow),
    .byte_count  (byte_count)
  );

  initial ucpd_clk = 1'b0;
  always #CLK_HALF ucpd_clk = ~ucpd_clk;

  // --------------------
  // run limit
  always @(posedge ucpd_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // --------------------
  // golden file reader
  function automatic bit next_token(input int fd, output string tok);
    string rest;
    tok = "";
    while ($fscanf(fd, "%s", tok) == 1)
    begin
      if (tok.getc(0) != "#")
        return 1'b1;
      void'($fgets(rest, fd));                             // drop the comment line
    end
    return 1'b0;
  endfunction

  function automatic bit keyword_ok(input int fd, input string kw);
    string tok;
    if (next_token(fd, tok) && (tok == kw))
      return 1'b1;
    $display("golden file: keyword %s missing", kw);
    return 1'b0;
  endfunction

  function automatic bit load_golden();
    int                    fd;
    int                    v;
    int                    k;
    int                    osk;
    int                    ci;
    int                    tf;
    int                    d;
    bit                    good;
    string                 tok;
    test_t                 t;
    ucpd_rx_pkg::rx_item_t it;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0)
    begin
      $display("golden file %s could not be opened", GOLDEN);
      return 1'b0;
    end
    good = 1'b1;
    while (good && next_token(fd, tok))
    begin
      good = (tok == "test") && ($fscanf(fd, "%s %d %d %d", t.name, t.hold, t.ovf, t.cnt) == 4);
      good = good && keyword_ok(fd, "sym") && ($fscanf(fd, "%d", t.nsym) == 1);
      for (int i = 0; good && (i < t.nsym); i++)
      begin
        good = ($fscanf(fd, "%h", v) == 1);
        syms.push_back(ucpd_rx_pkg::sym_t'(v));
      end
      good = good && keyword_ok(fd, "exp") && ($fscanf(fd, "%d", t.nexp) == 1);
      for (int i = 0; good && (i < t.nexp); i++)
      begin
        good = ($fscanf(fd, "%d %d %d %d %h", k, osk, ci, tf, d) == 5);
        it.kind                 = ucpd_rx_pkg::item_kind_e'(k);
        it.ordset.kind          = ucpd_rx_pkg::ordset_e'(osk);
        it.ordset.corrupt_idx   = 3'(ci);
        it.ordset.three_of_four = 1'(tf);
        it.data                 = 8'(d);
        exps.push_back(it);
      end
      tests.push_back(t);
    end
    $fclose(fd);
    if (!good)
      $display("golden file: malformed entry in test %0d", tests.size());
    return good && (tests.size() != 0);
  endfunction

  // --------------------
  // stimulus, everything moves 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge ucpd_clk);
    #DRIVE_DLY;
    if (ready_rand)
      item_ready = 1'($urandom_range(1, 0));
  endtask

  task automatic send_bit(input logic b);
    repeat ($urandom_range(3, 0)) next_cycle();            // idle gap on the line
    line_valid = 1'b1;
    line_bit   = b;
    next_cycle();
    line_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((u_chk.items_pending() != 0) && (n < DRAIN_MAX))
    begin
      next_cycle();
      n++;
    end
  endtask

  task automatic run_test(input test_t t);
    ucpd_rx_pkg::sym_t s;
    u_chk.start_test(t.name);
    for (int i = 0; i < t.nexp; i++)
      u_chk.expect_item(exps[exp_pos + i]);
    exp_pos += t.nexp;
    ready_rand = (t.hold == 0);
    if (t.hold != 0)
      item_ready = 1'b0;                                   // consumer stalls all frame
    frame_start = 1'b1;
    next_cycle();
    frame_start = 1'b0;
    u_chk.check_overflow(1'b0);                            // frame start clears it
    for (int i = 0; i < t.nsym; i++)
    begin
      s = syms[sym_pos + i];
      for (int b = 0; b < ucpd_rx_pkg::SYM_W; b++)
        send_bit(s[b]);                                    // lsb first
    end
    sym_pos += t.nsym;
    repeat (8) next_cycle();                               // last item reaches the fifo
    ready_rand = 1'b0;
    item_ready = 1'b1;
    wait_drain();
    repeat (8) next_cycle();                               // room for stray items
    u_chk.check_byte_count(ucpd_rx_pkg::byte_cnt_t'(t.cnt));
    u_chk.check_overflow(t.ovf != 0);
    u_chk.finish_test();
  endtask

  // --------------------
  // main sequence
  initial
  begin
    ic_rst_n    = 1'b0;
    frame_start = 1'b0;
    line_valid  = 1'b0;
    line_bit    = 1'b0;
    item_ready  = 1'b0;
    ready_rand  = 1'b0;
    sym_pos     = 0;
    exp_pos     = 0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    void'($urandom(32'h635b_41ca));
    loaded      = load_golden();
    cycle_limit = syms.size() * ucpd_rx_pkg::SYM_W * 4 + 200;  // worst gap is 4 cycles a bit
    repeat (10) next_cycle();
    ic_rst_n = 1'b1;
    if (loaded)
    begin
      foreach (tests[i])
        run_test(tests[i]);
    end
    u_chk.report_totals();
    if (loaded && (u_chk.total_errs == 0) && (u_chk.tests_run == tests.size()))
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- build.f
src/ucpd_rx_pkg.sv
src/ucpd_symbol_shifter.sv
src/ucpd_ordset_detector.sv
src/ucpd_data_decoder.sv
src/ucpd_rx_fifo.sv
src/ucpd_rx_top.sv
dv/ucpd_rx_checker.sv
dv/ucpd_rx_tb.sv

//--- Bender.yml
package:
  name: ucpd_rx

sources:
  - src/ucpd_rx_pkg.sv
  - src/ucpd_symbol_shifter.sv
  - src/ucpd_ordset_detector.sv
  - src/ucpd_data_decoder.sv
  - src/ucpd_rx_fifo.sv
  - src/ucpd_rx_top.sv
  - target: test
    files:
      - dv/ucpd_rx_checker.sv
      - dv/ucpd_rx_tb.sv

//--- dv/ucpd_rx_golden.txt
# test <name> <hold item_ready low> <expected overflow> <expected byte_count>
# sym <count> then 5-bit line symbols in hex, first sent first, each one lsb first
# exp <count> then per item: kind ordset_kind corrupt_idx three_of_four data_hex
# item kind 0 ordset 1 byte 2 eop 3 error, ordset kind 0 sop 1 sop1 2 sop2 3 hard 4 cable 5 invalid
test sop_4bytes 0 0 4
sym 13 18 18 18 11 14 09 0A 15 0B 16 1E 1D 0D
exp 6  0 0 0 0 00  1 0 0 0 12  1 0 0 0 34  1 0 0 0 A5  1 0 0 0 F0  2 0 0 0 04
test sop1_bad_k3 0 0 1
sym 7 18 18 00 06 16 0B 0D
exp 3  0 1 3 1 00  1 0 0 0 5A  2 0 0 0 01
test sop2_bad_k1 0 0 1
sym 7 1F 06 18 06 15 1A 0D
exp 3  0 2 1 1 00  1 0 0 0 C3  2 0 0 0 01
test hard_reset 0 0 0
sym 7 07 07 07 19 1E 09 0D
exp 1  0 3 0 0 00
test cable_reset 0 0 0
sym 6 07 18 07 06 14 09
exp 1  0 4 0 0 00
test overflow_hold 1 1 5
sym 15 18 18 18 11 09 1E 15 14 0B 0A 0F 0E 13 12 0D
exp 4  0 0 0 0 00  1 0 0 0 01  1 0 0 0 23  1 0 0 0 45
test invalid_os 0 0 0
sym 7 18 18 19 19 14 09 0D
exp 1  0 5 0 0 00
test bad_symbol 0 0 1
sym 9 18 18 18 11 14 09 0A 03 0D
exp 3  0 0 0 0 00  1 0 0 0 12  3 0 0 0 03
